/* hdl/address_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module address_shifter
	import frame_pkg::*;
#(
	parameter int ADDR_WIDTH = 14
)
(
	input  wire logic                  clock,
	input  wire logic                  reset,
	input  wire logic [ADDR_WIDTH-1:0] addr_in,
	input  wire burst_code_t           burst_mode_in,
	input  wire logic                  addr_load,
	input  wire logic                  addr_shift,
	input  wire logic                  code_shift,
	output logic                       addr_tx,
	output logic                       burst_mode
);

	logic [ADDR_WIDTH-1:0] addr_sreg;
	logic [2:0]            code_sreg;

	// both registers shift MSB first
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			addr_sreg <= '0;
			code_sreg <= '0;
		end
		else if (addr_load)
		begin
			addr_sreg <= addr_in;
			code_sreg <= burst_mode_in;
		end
		else
		begin
			if (addr_shift)
				addr_sreg <= {addr_sreg[ADDR_WIDTH-2:0], 1'b0};
			if (code_shift)
				code_sreg <= {code_sreg[1:0], 1'b0};
		end
	end

	// lines idle low outside their bit slots
	assign addr_tx    = addr_shift && addr_sreg[ADDR_WIDTH-1];
	assign burst_mode = code_shift && code_sreg[2];

endmodule

`default_nettype wire

/* hdl/beat_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module beat_counter
	import frame_pkg::*;
(
	input  wire logic  clock,
	input  wire logic  reset,
	input  wire burst_code_t burst_mode_in,
	input  wire logic  addr_load,
	input  wire logic  beat_advance,
	output logic       beats_done
);

	// wide enough for the longest burst, code 7
	localparam int COUNT_WIDTH = $clog2(BEAT_BASE << 6) + 1;

	logic [COUNT_WIDTH-1:0] beat_total;
	logic [COUNT_WIDTH-1:0] beats_sent;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			beat_total <= '0;
			beats_sent <= '0;
		end
		else if (addr_load)
		begin
			// BEAT_BASE doubled per code step above 1
			if (burst_mode_in == BURST_NONE)
				beat_total <= '0;
			else
				beat_total <= COUNT_WIDTH'(BEAT_BASE) << (int'(burst_mode_in) - 1);
			beats_sent <= '0;
		end
		else if (beat_advance)
		begin
			beats_sent <= beats_sent + 1'b1;
		end
	end

	// header frame counts as the first beat
	assign beats_done = (beats_sent >= beat_total);

endmodule

`default_nettype wire

/* hdl/bus_master_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_master_top
	import frame_pkg::*;
#(
	parameter int ADDR_WIDTH = 14,
	parameter int DATA_WIDTH = 8
)
(
	input  wire logic                  clock,
	input  wire logic                  reset,
	// user request side
	input  wire logic                  enable,
	input  wire logic                  read_en,
	input  wire logic [DATA_WIDTH-1:0] data_in,
	input  wire logic [ADDR_WIDTH-1:0] addr_in,
	input  wire burst_code_t           burst_mode_in,
	// serial bus side
	input  wire logic                  data_rx,
	input  wire logic                  slave_ready,
	input  wire logic                  bus_ready,
	input  wire logic                  slave_valid,
	output logic                       bus_req,
	output logic                       addr_tx,
	output logic                       data_tx,
	output logic                       valid_s,
	output logic                       write_en_slave,
	output logic                       burst_mode,
	output logic                       master_busy,
	output logic [DATA_WIDTH-1:0]      data_read
);

	// strobes from control to datapath
	logic addr_load;
	logic data_load;
	logic addr_shift;
	logic data_shift;
	logic code_shift;
	logic beat_advance;
	logic rx_shift;
	logic rx_publish;
	// beat count status back to control
	logic beats_done;

	//////////////////////////////
	// control
	//////////////////////////////

	transfer_control #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.DATA_WIDTH (DATA_WIDTH)
	) transfer_control_i (
		.clock          (clock),
		.reset          (reset),
		.enable         (enable),
		.read_en        (read_en),
		.burst_mode_in  (burst_mode_in),
		.bus_ready      (bus_ready),
		.slave_ready    (slave_ready),
		.slave_valid    (slave_valid),
		.beats_done     (beats_done),
		.bus_req        (bus_req),
		.valid_s        (valid_s),
		.write_en_slave (write_en_slave),
		.master_busy    (master_busy),
		.addr_load      (addr_load),
		.data_load      (data_load),
		.addr_shift     (addr_shift),
		.data_shift     (data_shift),
		.code_shift     (code_shift),
		.beat_advance   (beat_advance),
		.rx_shift       (rx_shift),
		.rx_publish     (rx_publish)
	);

	//////////////////////////////
	// datapath
	//////////////////////////////

	address_shifter #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) address_shifter_i (
		.clock         (clock),
		.reset         (reset),
		.addr_in       (addr_in),
		.burst_mode_in (burst_mode_in),
		.addr_load     (addr_load),
		.addr_shift    (addr_shift),
		.code_shift    (code_shift),
		.addr_tx       (addr_tx),
		.burst_mode    (burst_mode)
	);

	data_shifter #(
		.DATA_WIDTH (DATA_WIDTH)
	) data_shifter_i (
		.clock        (clock),
		.reset        (reset),
		.data_in      (data_in),
		.data_load    (data_load),
		.data_shift   (data_shift),
		.beat_advance (beat_advance),
		.data_tx      (data_tx)
	);

	read_shifter #(
		.DATA_WIDTH (DATA_WIDTH)
	) read_shifter_i (
		.clock      (clock),
		.reset      (reset),
		.data_rx    (data_rx),
		.rx_shift   (rx_shift),
		.rx_publish (rx_publish),
		.data_read  (data_read)
	);

	beat_counter beat_counter_i (
		.clock         (clock),
		.reset         (reset),
		.burst_mode_in (burst_mode_in),
		.addr_load     (addr_load),
		.beat_advance  (beat_advance),
		.beats_done    (beats_done)
	);

endmodule

`default_nettype wire

/* hdl/data_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module data_shifter
#(
	parameter int DATA_WIDTH = 8
)
(
	input  wire logic                  clock,
	input  wire logic                  reset,
	input  wire logic [DATA_WIDTH-1:0] data_in,
	input  wire logic                  data_load,
	input  wire logic                  data_shift,
	input  wire logic                  beat_advance,
	output logic                       data_tx
);

	// value of the current beat
	logic [DATA_WIDTH-1:0] data_base;
	// bits still to go out
	logic [DATA_WIDTH-1:0] data_sreg;
	logic [DATA_WIDTH-1:0] next_base;

	// wraps modulo 2^DATA_WIDTH
	assign next_base = data_base + 1'b1;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			data_base <= '0;
			data_sreg <= '0;
		end
		else if (data_load)
		begin
			data_base <= data_in;
			data_sreg <= data_in;
		end
		// last bit of a frame, so set up the next beat
		else if (beat_advance)
		begin
			data_base <= next_base;
			data_sreg <= next_base;
		end
		else if (data_shift)
		begin
			data_sreg <= {data_sreg[DATA_WIDTH-2:0], 1'b0};
		end
	end

	// MSB first, low outside data slots
	assign data_tx = data_shift && data_sreg[DATA_WIDTH-1];

endmodule

`default_nettype wire

/* hdl/frame_pkg.sv */
`default_nettype none

package frame_pkg;

	//////////////////////////////
	// serial frame format
	//////////////////////////////

	// burst length code sent on burst_mode
	// code n > 0 means 8 * 2^(n-1) beats, header included
	typedef enum logic [2:0]
	{
		BURST_NONE = 3'd0,
		BURST_8    = 3'd1,
		BURST_16   = 3'd2,
		BURST_32   = 3'd3,
		BURST_64   = 3'd4,
		BURST_128  = 3'd5,
		BURST_256  = 3'd6,
		BURST_512  = 3'd7
	} burst_code_t;

	// header bit where data_tx starts carrying write data
	localparam int DATA_START_BIT = 6;

	// header bit where burst_mode starts carrying the code
	localparam int BURST_CODE_START_BIT = 11;

	// beats for code 1
	localparam int BEAT_BASE = 8;

endpackage

`default_nettype wire

/* hdl/master_ctrl_pkg.sv */
`default_nettype none

package master_ctrl_pkg;

	//////////////////////////////
	// controller encodings
	//////////////////////////////

	// transfer FSM states
	typedef enum logic [3:0]
	{
		IDLE      = 4'd0,
		// waiting for bus_ready
		REQUEST   = 4'd1,
		// address frame on the wire
		HEADER    = 4'd2,
		READ_WAIT = 4'd3,
		READ_DATA = 4'd4,
		// between burst beats
		BEAT_WAIT = 4'd5,
		BEAT_DATA = 4'd6
	} ctrl_state_t;

	// kind of transfer latched at request time
	typedef enum logic [1:0]
	{
		OP_WRITE       = 2'd0,
		OP_READ        = 2'd1,
		OP_BURST_WRITE = 2'd2
	} xfer_op_t;

endpackage

`default_nettype wire

/* hdl/read_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module read_shifter
#(
	parameter int DATA_WIDTH = 8
)
(
	input  wire logic                  clock,
	input  wire logic                  reset,
	input  wire logic                  data_rx,
	input  wire logic                  rx_shift,
	input  wire logic                  rx_publish,
	output logic [DATA_WIDTH-1:0]      data_read
);

	// partial byte while bits arrive
	logic [DATA_WIDTH-1:0] rx_sreg;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			rx_sreg   <= '0;
			data_read <= '0;
		end
		else
		begin
			// first bit received ends up as the MSB
			if (rx_shift)
				rx_sreg <= {rx_sreg[DATA_WIDTH-2:0], data_rx};
			// holds until the next read completes
			if (rx_publish)
				data_read <= rx_sreg;
		end
	end

endmodule

`default_nettype wire

/* hdl/transfer_control.sv */
`timescale 1ns/1ps
`default_nettype none

module transfer_control
	import frame_pkg::*;
	import master_ctrl_pkg::*;
#(
	parameter int ADDR_WIDTH = 14,
	parameter int DATA_WIDTH = 8
)
(
	input  wire logic  clock,
	input  wire logic  reset,
	input  wire logic  enable,
	input  wire logic  read_en,
	input  wire burst_code_t burst_mode_in,
	input  wire logic  bus_ready,
	input  wire logic  slave_ready,
	input  wire logic  slave_valid,
	input  wire logic  beats_done,
	output logic       bus_req,
	output logic       valid_s,
	output logic       write_en_slave,
	output logic       master_busy,
	output logic       addr_load,
	output logic       data_load,
	output logic       addr_shift,
	output logic       data_shift,
	output logic       code_shift,
	output logic       beat_advance,
	output logic       rx_shift,
	output logic       rx_publish
);

	// counter must reach DATA_WIDTH in READ_DATA (publish slot)
	localparam int CNT_WIDTH =
		$clog2(((ADDR_WIDTH > DATA_WIDTH) ? ADDR_WIDTH : DATA_WIDTH) + 1);
	localparam logic [CNT_WIDTH-1:0] HEADER_LAST = CNT_WIDTH'(ADDR_WIDTH - 1);
	localparam logic [CNT_WIDTH-1:0] BEAT_LAST   = CNT_WIDTH'(DATA_WIDTH - 1);
	localparam logic [CNT_WIDTH-1:0] RX_PUBLISH  = CNT_WIDTH'(DATA_WIDTH);

	ctrl_state_t          state;
	ctrl_state_t          next_state;
	xfer_op_t             op;
	logic [CNT_WIDTH-1:0] bit_count;
	logic                 header_bit;
	logic                 header_last;
	logic                 beat_bit;
	logic                 beat_last;
	logic                 rx_bit;

	//////////////////////////////
	// frame position decode
	//////////////////////////////

	assign header_bit  = (state == HEADER);
	assign header_last = header_bit && (bit_count == HEADER_LAST);
	assign beat_bit    = (state == BEAT_DATA);
	assign beat_last   = beat_bit && (bit_count == BEAT_LAST);
	assign rx_bit      = (state == READ_DATA);

	// request capture, only seen while idle
	assign addr_load = (state == IDLE) && enable;
	assign data_load = (state == IDLE) && enable;

	// address goes out on every header bit
	assign addr_shift = header_bit;
	// write data rides the address tail, or fills a whole beat
	assign data_shift = (header_bit && (op != OP_READ)
		&& (int'(bit_count) >= DATA_START_BIT)) || beat_bit;
	// burst code on the last header bits
	assign code_shift = header_bit && (op == OP_BURST_WRITE)
		&& (int'(bit_count) >= BURST_CODE_START_BIT);

	// every write frame counts as one beat, header included
	assign beat_advance = (header_last && (op != OP_READ)) || beat_last;

	// 8 sample slots, then one slot to publish
	assign rx_shift   = rx_bit && (bit_count != RX_PUBLISH);
	assign rx_publish = rx_bit && (bit_count == RX_PUBLISH);

	assign valid_s     = header_bit || beat_bit;
	assign master_busy = (state != IDLE);
	assign bus_req     = (state != IDLE);

	//////////////////////////////
	// next state
	//////////////////////////////

	always_comb
	begin
		next_state = state;
		case (state)
			IDLE:
				if (enable)
					next_state = REQUEST;
			// frame only starts once the bus is granted
			REQUEST:
				if (bus_ready)
					next_state = HEADER;
			HEADER:
				if (header_last)
				begin
					case (op)
						OP_READ:        next_state = READ_WAIT;
						OP_BURST_WRITE: next_state = BEAT_WAIT;
						default:        next_state = IDLE;
					endcase
				end
			READ_WAIT:
				if (slave_valid)
					next_state = READ_DATA;
			READ_DATA:
				if (rx_publish)
					next_state = IDLE;
			// beats_done already reflects the frame just sent
			BEAT_WAIT:
				if (beats_done)
					next_state = IDLE;
				else if (slave_ready)
					next_state = BEAT_DATA;
			BEAT_DATA:
				if (beat_last)
					next_state = BEAT_WAIT;
			default:
				next_state = IDLE;
		endcase
	end

	//////////////////////////////
	// state, op and bit counter
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state          <= IDLE;
			op             <= OP_WRITE;
			bit_count      <= '0;
			write_en_slave <= 1'b0;
		end
		else
		begin
			state <= next_state;
			// latch the kind of transfer with the request
			if (addr_load)
			begin
				write_en_slave <= !read_en;
				if (read_en)
					op <= OP_READ;
				else if (burst_mode_in != BURST_NONE)
					op <= OP_BURST_WRITE;
				else
					op <= OP_WRITE;
			end
			// count restarts on every state change
			if (next_state != state)
				bit_count <= '0;
			else if (header_bit || beat_bit || rx_bit)
				bit_count <= bit_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build the bus master testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module bus_master_tb \
	-f vlog.f \
	-o bus_master_sim \
	&& ./obj_dir/bus_master_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" \
	&& echo "run_sim: passed" \
	|| { echo "run_sim: failed"; exit 1; }

/* verification/bus_master_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_master_checker
#(
	parameter int ADDR_WIDTH = 14
)
(
	input wire logic clock,
	input wire logic reset,
	input wire logic valid_s,
	input wire logic burst_mode,
	input wire logic master_busy
);

	// length of the current valid_s run
	int unsigned run_len;
	// header of this transfer already over
	logic        header_seen;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			run_len     <= 0;
			header_seen <= 1'b0;
		end
		else
		begin
			if (valid_s)
				run_len <= run_len + 1;
			else
				run_len <= 0;
			// first run of a transfer is the header
			if (!master_busy)
				header_seen <= 1'b0;
			else if (!valid_s && (run_len != 0))
				header_seen <= 1'b1;
		end
	end

	//////////////////////////////
	// frame protocol
	//////////////////////////////

	header_length: assert property (
		@(posedge clock) disable iff (reset)
		(!valid_s && (run_len != 0) && !header_seen) |-> (run_len == ADDR_WIDTH)
	) else $error("header held valid_s for %0d cycles", run_len);

	// code line idles low between frames
	code_low_when_idle: assert property (
		@(posedge clock) disable iff (reset)
		!valid_s |-> !burst_mode
	) else $error("burst_mode high outside a frame");

	busy_during_frame: assert property (
		@(posedge clock) disable iff (reset)
		valid_s |-> master_busy
	) else $error("valid_s high while master_busy low");

endmodule

bind bus_master_top bus_master_checker #(
	.ADDR_WIDTH (ADDR_WIDTH)
) bus_master_checker_i (
	.clock       (clock),
	.reset       (reset),
	.valid_s     (valid_s),
	.burst_mode  (burst_mode),
	.master_busy (master_busy)
);

`default_nettype wire

/* verification/bus_master_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_master_tb
	import frame_pkg::*;
	import master_ctrl_pkg::*;
();

	localparam int ADDR_WIDTH   = 14;
	localparam int DATA_WIDTH   = 8;
	localparam int MAX_VECTORS  = 32;
	localparam int RESET_CYCLES = 5;
	// cycle budget for the watchdog
	localparam int CYCLES_PER_VECTOR = 40;
	localparam int CYCLES_PER_BEAT   = 20;
	localparam logic [31:0] SEED     = 32'h797b_ac57;

	logic                  clock;
	logic                  reset;
	logic                  enable;
	logic                  read_en;
	logic [DATA_WIDTH-1:0] data_in;
	logic [ADDR_WIDTH-1:0] addr_in;
	burst_code_t           burst_mode_in;
	logic                  data_rx;
	logic                  slave_ready;
	logic                  bus_ready;
	logic                  slave_valid;
	logic                  bus_req;
	logic                  addr_tx;
	logic                  data_tx;
	logic                  valid_s;
	logic                  write_en_slave;
	logic                  burst_mode;
	logic                  master_busy;
	logic [DATA_WIDTH-1:0] data_read;

	// op, code, addr, wdata, rbyte
	logic [39:0] vectors [MAX_VECTORS];
	integer      seed;
	int          vector_count;
	int          cycle_count     = 0;
	int          cycle_limit     = 0;
	int          check_count     = 0;
	int          value_errors    = 0;
	int          protocol_errors = 0;
	int          header_count    = 0;

	// frames seen on the wire, oldest first
	int                    len_q  [$];
	logic [ADDR_WIDTH-1:0] addr_q [$];
	logic [DATA_WIDTH-1:0] data_q [$];
	burst_code_t           code_q [$];

	bus_master_top #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.DATA_WIDTH (DATA_WIDTH)
	) bus_master_top_i (
		.clock          (clock),
		.reset          (reset),
		.enable         (enable),
		.read_en        (read_en),
		.data_in        (data_in),
		.addr_in        (addr_in),
		.burst_mode_in  (burst_mode_in),
		.data_rx        (data_rx),
		.slave_ready    (slave_ready),
		.bus_ready      (bus_ready),
		.slave_valid    (slave_valid),
		.bus_req        (bus_req),
		.addr_tx        (addr_tx),
		.data_tx        (data_tx),
		.valid_s        (valid_s),
		.write_en_slave (write_en_slave),
		.burst_mode     (burst_mode),
		.master_busy    (master_busy),
		.data_read      (data_read)
	);

	always #50 clock = ~clock;

	// watchdog
	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if ((cycle_limit > 0) && (cycle_count >= cycle_limit))
		begin
			$display("timeout after %0d cycles, transfers never completed", cycle_count);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	//////////////////////////////
	// compare tasks
	//////////////////////////////

	task automatic check_addr(input logic [ADDR_WIDTH-1:0] got, input logic [ADDR_WIDTH-1:0] exp);
		check_count++;
		if (got !== exp)
		begin
			value_errors++;
			$display("FAILED addr_tx: got 0x%h expected 0x%h", got, exp);
		end
	endtask

	task automatic check_data(input logic [DATA_WIDTH-1:0] got, input logic [DATA_WIDTH-1:0] exp);
		check_count++;
		if (got !== exp)
		begin
			value_errors++;
			$display("FAILED data_tx: got 0x%h expected 0x%h", got, exp);
		end
	endtask

	task automatic check_code(input burst_code_t got, input burst_code_t exp);
		check_count++;
		if (got !== exp)
		begin
			value_errors++;
			$display("FAILED burst_mode: got 0x%h expected 0x%h", got, exp);
		end
	endtask

	task automatic check_read(input logic [DATA_WIDTH-1:0] got, input logic [DATA_WIDTH-1:0] exp);
		check_count++;
		if (got !== exp)
		begin
			value_errors++;
			$display("FAILED data_read: got 0x%h expected 0x%h", got, exp);
		end
	endtask

	// single status lines
	task automatic check_flag(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp)
		begin
			value_errors++;
			$display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic report_protocol(input string msg);
		protocol_errors++;
		$display("%s", msg);
	endtask

	task automatic check_length(input string what, input int got, input int exp);
		check_count++;
		if (got != exp)
			report_protocol($sformatf("%s frame lasted %0d cycles, not %0d", what, got, exp));
	endtask

	//////////////////////////////
	// slave side monitor
	//////////////////////////////

	// collects frames, checks that each start was granted
	always @(negedge clock)
	begin : frame_monitor
		int                    frame_len;
		logic [ADDR_WIDTH-1:0] addr_bits;
		logic [DATA_WIDTH-1:0] data_bits;
		logic [2:0]            code_bits;
		logic                  header_pending;
		logic                  bus_ready_seen;
		logic                  slave_ready_seen;
		if (reset)
		begin
			frame_len        = 0;
			header_pending   = 1'b1;
			bus_ready_seen   = 1'b0;
			slave_ready_seen = 1'b0;
		end
		else if (valid_s)
		begin
			if (frame_len == 0)
			begin
				if (header_pending && !bus_ready_seen)
					report_protocol("header started before bus_ready was raised");
				if (!header_pending && !slave_ready_seen)
					report_protocol("burst beat started before slave_ready was raised");
				if (header_pending)
					header_count++;
				header_pending   = 1'b0;
				bus_ready_seen   = 1'b0;
				slave_ready_seen = 1'b0;
			end
			frame_len++;
			// last 8 and last 3 bits land in data and code
			addr_bits = {addr_bits[ADDR_WIDTH-2:0], addr_tx};
			data_bits = {data_bits[DATA_WIDTH-2:0], data_tx};
			code_bits = {code_bits[1:0], burst_mode};
		end
		else
		begin
			// frame just ended
			if (frame_len != 0)
			begin
				len_q.push_back(frame_len);
				addr_q.push_back(addr_bits);
				data_q.push_back(data_bits);
				code_q.push_back(burst_code_t'(code_bits));
				frame_len = 0;
			end
			if (!master_busy)
				header_pending = 1'b1;
			if (bus_ready)
				bus_ready_seen = 1'b1;
			if (slave_ready)
				slave_ready_seen = 1'b1;
		end
	end

	//////////////////////////////
	// stimulus helpers
	//////////////////////////////

	// data frames of one vector, header counted as one
	function automatic int beats_of(input logic [39:0] vec);
		if (xfer_op_t'(vec[37:36]) == OP_BURST_WRITE)
			return 8 << (int'(vec[34:32]) - 1);
		return 1;
	endfunction

	task automatic wait_random();
		int delay;
		delay = $random(seed) & 7;
		@(posedge clock);
		repeat (delay) @(posedge clock);
	endtask

	task automatic wait_frame_start();
		do @(negedge clock); while (!valid_s);
	endtask

	task automatic wait_idle();
		do @(negedge clock); while (master_busy);
	endtask

	task automatic next_frame(
		output int                    len,
		output logic [ADDR_WIDTH-1:0] addr,
		output logic [DATA_WIDTH-1:0] data,
		output burst_code_t           code
	);
		while (len_q.size() == 0)
			@(negedge clock);
		len  = len_q.pop_front();
		addr = addr_q.pop_front();
		data = data_q.pop_front();
		code = code_q.pop_front();
	endtask

	task automatic run_vector(input logic [39:0] vec);
		xfer_op_t              op;
		burst_code_t           code;
		logic [ADDR_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0] data;
		logic [DATA_WIDTH-1:0] ret;
		int                    beats;
		int                    len;
		int                    i;
		logic [ADDR_WIDTH-1:0] got_addr;
		logic [DATA_WIDTH-1:0] got_data;
		burst_code_t           got_code;
		op   = xfer_op_t'(vec[37:36]);
		code = burst_code_t'(vec[34:32]);
		addr = vec[16 +: ADDR_WIDTH];
		data = vec[8 +: DATA_WIDTH];
		ret  = vec[0 +: DATA_WIDTH];
		@(posedge clock);
		enable        <= 1'b1;
		read_en       <= (op == OP_READ);
		addr_in       <= addr;
		data_in       <= data;
		burst_mode_in <= code;
		@(posedge clock);
		enable <= 1'b0;
		// grant after a random wait
		wait_random();
		bus_ready <= 1'b1;
		wait_frame_start();
		// request held while the header is on the wire
		check_flag("bus_req", bus_req, 1'b1);
		@(posedge clock);
		bus_ready <= 1'b0;
		// stray request mid header, must not start a transfer
		enable <= 1'b1;
		@(posedge clock);
		enable <= 1'b0;
		next_frame(len, got_addr, got_data, got_code);
		check_length("header", len, ADDR_WIDTH);
		check_addr(got_addr, addr);
		check_flag("write_en_slave", write_en_slave, op != OP_READ);
		if (op == OP_READ)
		begin
			wait_random();
			slave_valid <= 1'b1;
			@(posedge clock);
			slave_valid <= 1'b0;
			// return byte, MSB first
			for (i = DATA_WIDTH - 1; i >= 0; i--)
			begin
				data_rx <= ret[i];
				@(posedge clock);
			end
			data_rx <= 1'b0;
			wait_idle();
			check_read(data_read, ret);
		end
		else
		begin
			check_data(got_data, data);
			if (op == OP_BURST_WRITE)
			begin
				check_code(got_code, code);
				// total beats minus the header
				beats = (8 << (int'(code) - 1)) - 1;
				for (i = 1; i <= beats; i++)
				begin
					wait_random();
					slave_ready <= 1'b1;
					wait_frame_start();
					@(posedge clock);
					slave_ready <= 1'b0;
					next_frame(len, got_addr, got_data, got_code);
					check_length("beat", len, DATA_WIDTH);
					check_data(got_data, data + DATA_WIDTH'(i));
				end
			end
			wait_idle();
		end
		// request line dropped with the transfer
		check_flag("bus_req", bus_req, 1'b0);
		if (len_q.size() != 0)
			report_protocol("extra frame on the bus after the transfer ended");
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial
	begin : stimulus
		int i;
		clock         = 1'b0;
		reset         = 1'b1;
		enable        = 1'b0;
		read_en       = 1'b0;
		data_in       = '0;
		addr_in       = '0;
		burst_mode_in = BURST_NONE;
		data_rx       = 1'b0;
		slave_ready   = 1'b0;
		bus_ready     = 1'b0;
		slave_valid   = 1'b0;
		seed          = SEED;
		// op field f marks unused entries
		for (i = 0; i < MAX_VECTORS; i++)
			vectors[i] = '1;
		$readmemh("verification/bus_master_vectors.txt", vectors);
		vector_count = 0;
		while ((vector_count < MAX_VECTORS) && (vectors[vector_count][39:36] != 4'hf))
			vector_count++;
		if (vector_count == 0)
			report_protocol("no vectors read from the vector file");
		cycle_limit = 4 * RESET_CYCLES;
		for (i = 0; i < vector_count; i++)
			cycle_limit += CYCLES_PER_VECTOR + CYCLES_PER_BEAT * beats_of(vectors[i]);

		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_flag("bus_req", bus_req, 1'b0);
		check_flag("valid_s", valid_s, 1'b0);
		check_flag("master_busy", master_busy, 1'b0);
		check_read(data_read, '0);

		for (i = 0; i < vector_count; i++)
			run_vector(vectors[i]);

		// stray enables must not add headers
		if (header_count != vector_count)
			report_protocol($sformatf("%0d headers seen for %0d requests",
				header_count, vector_count));

		$display("checks %0d, value errors %0d, protocol errors %0d",
			check_count, value_errors, protocol_errors);
		if ((value_errors == 0) && (protocol_errors == 0))
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/bus_master_vectors.txt */
// one transfer per line, ten hex digits: op(1) code(1) addr(4) wdata(2) rbyte(2)
// op 0 write, 1 read, 2 burst write; rbyte is what the slave returns on a read
003A5CA700
101234005E
212AF0FC00
0000018000
103FFF00C3
22155A1000
1000000001
230ABCF000
003FFFFF00
// longest burst, data wraps past ff
2720010000
102AAA00AA
0015555500
101C3E0096
210F0F7F00

/* vlog.f */
hdl/frame_pkg.sv
hdl/master_ctrl_pkg.sv
hdl/address_shifter.sv
hdl/data_shifter.sv
hdl/read_shifter.sv
hdl/beat_counter.sv
hdl/transfer_control.sv
hdl/bus_master_top.sv
verification/bus_master_checker.sv
verification/bus_master_tb.sv
